// ==== compile.f ====
+incdir+src
src/ps2_pkg.sv
src/ps2_frame_rx.sv
src/char_fifo.sv
src/character_buffer_32.sv
test/tb_character_buffer_32.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it into a log and look for the pass line.

cd "$(dirname "$0")" || exit 1

TOP=tb_character_buffer_32
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    -f compile.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

// ==== src/char_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2_consts.svh"

module char_fifo (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       write,
    input  wire logic [7:0] data_in,
    input  wire logic       read,
    output logic [7:0]      out,
    output logic            empty,
    output logic            full,
    output logic            overflow
);

    localparam int ADDR_W = `CHAR_ADDR_W;
    localparam int DEPTH  = 1 << ADDR_W;

    logic [7:0]        mem [DEPTH];
    logic [ADDR_W-1:0] first_addr;  // oldest entry
    logic [ADDR_W-1:0] last_addr;   // next free slot
    logic [ADDR_W:0]   count;
    logic              do_write;
    logic              do_read;

    // ************************************************************
    // status flags and accepted operations
    // ************************************************************

    assign empty = (count == '0);
    assign full  = count[ADDR_W];  // count only reaches DEPTH when full

    assign do_write = write & ~full;  // a write into a full buffer is dropped
    assign do_read  = read & ~empty;  // a read of an empty buffer is ignored

    // first word fall through
    assign out = mem[first_addr];

    // ************************************************************
    // storage
    // ************************************************************

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[last_addr] <= data_in;
        end
    end

    // ************************************************************
    // pointers, occupancy and overflow
    // ************************************************************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            first_addr <= '0;
            last_addr  <= '0;
            count      <= '0;
            overflow   <= 1'b0;
        end else begin
            overflow <= write & full;

            if (do_write) begin
                last_addr <= last_addr + 1'b1;  // wraps at the depth
            end

            if (do_read) begin
                first_addr <= first_addr + 1'b1;
            end

            case ({do_write, do_read})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;  // none, or both in the same cycle
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/character_buffer_32.sv ====
`timescale 1ns/1ps
`default_nettype none

module character_buffer_32
    import ps2_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       ps2_clk,
    input  wire logic       ps2_data,
    input  wire logic       read,
    output logic [7:0]      out,
    output logic            empty,
    output logic            full,
    output logic            frame_error,
    output logic            overflow
);

    rx_char_t rx_char;
    logic     char_strobe;
    logic     char_write;

    // ************************************************************
    // PS/2 frame receiver
    // ************************************************************

    ps2_frame_rx u_frame_rx (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .rx_char     (rx_char),
        .char_strobe (char_strobe)
    );

    // only clean frames reach the buffer, the rest are reported
    assign char_write  = char_strobe & (rx_char.status == FRAME_OK);
    assign frame_error = char_strobe & (rx_char.status != FRAME_OK);

    // ************************************************************
    // character buffer
    // ************************************************************

    char_fifo u_char_fifo (
        .clk      (clk),
        .reset    (reset),
        .write    (char_write),
        .data_in  (rx_char.data),
        .read     (read),
        .out      (out),
        .empty    (empty),
        .full     (full),
        .overflow (overflow)
    );

endmodule

`default_nettype wire

// ==== src/ps2_consts.svh ====
`ifndef PS2_CONSTS_SVH
`define PS2_CONSTS_SVH

// ************************************************************
// sizing of the character buffer and the PS/2 receiver
// ************************************************************

// address width of the character buffer, depth is 2 to this power
`define CHAR_ADDR_W 5

// flops in each pin synchroniser, at least 2
`define PS2_SYNC_STAGES 2

// system clocks without a PS/2 clock edge before a partial frame is dropped
`define PS2_IDLE_TIMEOUT 64

`endif

// ==== src/ps2_frame_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2_consts.svh"

module ps2_frame_rx
    import ps2_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     ps2_clk,
    input  wire logic     ps2_data,
    output rx_char_t      rx_char,
    output logic          char_strobe
);

    localparam int SYNC_STAGES = `PS2_SYNC_STAGES;
    localparam int IDLE_W      = $clog2(`PS2_IDLE_TIMEOUT);
    localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(`PS2_IDLE_TIMEOUT - 1);

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] data_sync;
    logic                   clk_prev;
    logic                   ps2_fall;
    logic                   data_bit;

    rx_state_e              state;
    logic [2:0]             bit_cnt;
    logic [IDLE_W-1:0]      idle_cnt;
    logic [7:0]             shift_reg;
    logic                   parity_bit;
    frame_status_e          status_next;

    // ************************************************************
    // pin synchronisers and falling edge detect
    // ************************************************************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clk_sync  <= '1;  // both PS/2 lines idle high
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[SYNC_STAGES-2:0], ps2_clk};
            data_sync <= {data_sync[SYNC_STAGES-2:0], ps2_data};
            clk_prev  <= clk_sync[SYNC_STAGES-1];
        end
    end

    assign ps2_fall = clk_prev & ~clk_sync[SYNC_STAGES-1];
    assign data_bit = data_sync[SYNC_STAGES-1];  // same delay as the clock, so aligned

    // ************************************************************
    // frame state machine and idle timeout
    // ************************************************************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= RX_IDLE;
            bit_cnt     <= '0;
            idle_cnt    <= '0;
            char_strobe <= 1'b0;
        end else begin
            char_strobe <= 1'b0;

            if (state == RX_IDLE || ps2_fall) begin
                idle_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end

            if (ps2_fall) begin
                case (state)
                    RX_IDLE: begin
                        if (!data_bit) begin  // a start bit of 1 is ignored
                            state   <= RX_DATA;
                            bit_cnt <= '0;
                        end
                    end
                    RX_DATA: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_PARITY;
                        end
                    end
                    RX_PARITY: begin
                        state <= RX_STOP;
                    end
                    RX_STOP: begin
                        state       <= RX_IDLE;
                        char_strobe <= 1'b1;  // one pulse per frame, good or bad
                    end
                    default: begin
                        state <= RX_IDLE;
                    end
                endcase
            end else if (state != RX_IDLE && idle_cnt == IDLE_LAST) begin
                state <= RX_IDLE;  // stalled frame, resynchronise on the next start bit
            end
        end
    end

    // ************************************************************
    // data path
    // ************************************************************

    // odd parity means an odd number of ones over data and parity bit
    always_comb begin
        if (^{shift_reg, parity_bit} == 1'b0) begin
            status_next = FRAME_PARITY_ERR;
        end else if (!data_bit) begin
            status_next = FRAME_STOP_ERR;
        end else begin
            status_next = FRAME_OK;
        end
    end

    always_ff @(posedge clk) begin
        if (ps2_fall) begin
            case (state)
                RX_DATA: begin
                    shift_reg <= {data_bit, shift_reg[7:1]};  // lsb arrives first
                end
                RX_PARITY: begin
                    parity_bit <= data_bit;
                end
                RX_STOP: begin
                    rx_char.data   <= shift_reg;
                    rx_char.status <= status_next;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/ps2_pkg.sv ====
`default_nettype none

// ************************************************************
// shared types of the PS/2 receive path
// ************************************************************

package ps2_pkg;

    // phases of one 11-bit PS/2 frame after the start bit
    typedef enum logic [1:0] {
        RX_IDLE   = 2'd0,  // waiting for a start bit of 0
        RX_DATA   = 2'd1,  // eight data bits, lsb first
        RX_PARITY = 2'd2,  // odd parity bit
        RX_STOP   = 2'd3   // stop bit, expected to be 1
    } rx_state_e;

    // outcome of the checks made when the stop bit arrives
    typedef enum logic [1:0] {
        FRAME_OK         = 2'd0,
        FRAME_PARITY_ERR = 2'd1,  // parity is checked first
        FRAME_STOP_ERR   = 2'd2
    } frame_status_e;

    // one received character with its check result
    typedef struct packed {
        logic [7:0]    data;
        frame_status_e status;
    } rx_char_t;

endpackage

`default_nettype wire

// ==== test/tb_character_buffer_32.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2_consts.svh"

module tb_character_buffer_32;

    import ps2_pkg::*;

    localparam int DEPTH          = 1 << `CHAR_ADDR_W;
    localparam int TIMEOUT_CYCLES = 20000;  // about 60 frames of 220 cycles plus reads and waits

    logic       clk;
    logic       reset;
    logic       ps2_clk;
    logic       ps2_data;
    logic       read;
    logic [7:0] out;
    logic       empty;
    logic       full;
    logic       frame_error;
    logic       overflow;

    logic [7:0]  model_q[$];  // expected buffer contents, head is the oldest
    logic [31:0] lfsr;
    int          cycles;
    int          quiet_until;  // out, empty and full are not compared before this cycle
    int          exp_ferr;
    int          exp_ovf;
    int          seen_ferr;
    int          seen_ovf;
    int          check_errors;
    int          seq_errors;

    character_buffer_32 uut (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .read        (read),
        .out         (out),
        .empty       (empty),
        .full        (full),
        .frame_error (frame_error),
        .overflow    (overflow)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ************************************************************
    // continuous checks, sampled at the falling clock edge
    // ************************************************************

    always @(negedge clk) begin
        if (!reset) begin
            if (frame_error) begin
                assert (seen_ferr < exp_ferr) else begin
                    check_errors++;
                    $display("Fail %0t: frame_error expected 0 got 1", $time);
                end
                seen_ferr++;
            end
            if (overflow) begin
                assert (seen_ovf < exp_ovf) else begin
                    check_errors++;
                    $display("Fail %0t: overflow expected 0 got 1", $time);
                end
                seen_ovf++;
            end
            if (cycles >= quiet_until) begin  // write latency has passed
                assert (empty === (model_q.size() == 0)) else begin
                    check_errors++;
                    $display("Fail %0t: empty expected %b got %b", $time,
                             model_q.size() == 0, empty);
                end
                assert (full === (model_q.size() == DEPTH)) else begin
                    check_errors++;
                    $display("Fail %0t: full expected %b got %b", $time,
                             model_q.size() == DEPTH, full);
                end
                if (model_q.size() > 0) begin
                    assert (out === model_q[0]) else begin
                        check_errors++;
                        $display("Fail %0t: out expected %h got %h", $time, model_q[0], out);
                    end
                end
            end
        end
    end

    // ************************************************************
    // stimulus helpers
    // ************************************************************

    task step(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task next_byte(output logic [7:0] b);
        int k;
        for (k = 0; k < 8; k++) begin
            lfsr = lfsr_next(lfsr);
            b[k] = lfsr[0];
        end
    endtask

    // model update at the moment the stop bit edge is driven
    task record_frame(input logic [7:0] data, input bit bad);
        quiet_until = cycles + 8;
        if (bad) begin
            exp_ferr++;
        end else if (model_q.size() == DEPTH) begin
            exp_ovf++;  // newest character is dropped
        end else begin
            model_q.push_back(data);
        end
    endtask

    // keyboard side of one frame, bits_sent below 11 stalls the frame
    task send_frame(input logic [7:0] data, input bit bad_parity, input bit bad_stop,
                    input int bits_sent);
        logic [10:0] bits;
        logic        parity;
        int          i;
        parity = ~^data;  // odd parity
        if (bad_parity) begin
            parity = ~parity;
        end
        bits = {~bad_stop, parity, data, 1'b0};
        for (i = 0; i < bits_sent; i++) begin
            ps2_data = bits[i];
            step(10);
            ps2_clk = 1'b0;
            if (i == 10) begin
                record_frame(data, bad_parity || bad_stop);
            end
            step(10);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    task send_random(input int n);
        logic [7:0] b;
        repeat (n) begin
            next_byte(b);
            send_frame(b, 1'b0, 1'b0, 11);
        end
    endtask

    task read_char();
        if (model_q.size() > 0) begin
            assert (out === model_q[0]) else begin
                seq_errors++;
                $display("Fail %0t: out expected %h got %h", $time, model_q[0], out);
            end
        end
        read = 1'b1;
        step(1);
        read = 1'b0;
        if (model_q.size() > 0) begin
            void'(model_q.pop_front());
        end
    endtask

    task expect_flag(input string name, input logic actual, input logic expected);
        assert (actual === expected) else begin
            seq_errors++;
            $display("Fail %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    task expect_pulses();
        assert (seen_ferr == exp_ferr) else begin
            seq_errors++;
            $display("Fail %0t: frame_error pulses expected %0d got %0d", $time,
                     exp_ferr, seen_ferr);
        end
        assert (seen_ovf == exp_ovf) else begin
            seq_errors++;
            $display("Fail %0t: overflow pulses expected %0d got %0d", $time,
                     exp_ovf, seen_ovf);
        end
    endtask

    // ************************************************************
    // test sequence
    // ************************************************************

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        ps2_clk      = 1'b1;
        ps2_data     = 1'b1;
        read         = 1'b0;
        lfsr         = 32'h262b79d4;
        cycles       = 0;
        quiet_until  = 0;
        exp_ferr     = 0;
        exp_ovf      = 0;
        seen_ferr    = 0;
        seen_ovf     = 0;
        check_errors = 0;
        seq_errors   = 0;
        step(2);
        reset = 1'b0;
        expect_flag("empty", empty, 1'b1);
        expect_flag("full", full, 1'b0);

        send_random(20);  // in-order delivery
        repeat (20) read_char();
        expect_flag("empty", empty, 1'b1);
        expect_pulses();

        send_random(1);  // parity error leaves the stored character in place
        send_frame(8'h5a, 1'b1, 1'b0, 11);
        expect_pulses();
        read_char();

        send_frame(8'hc3, 1'b0, 1'b1, 11);  // stop bit of 0
        expect_pulses();
        send_random(1);
        read_char();
        expect_flag("empty", empty, 1'b1);

        send_random(DEPTH);  // fill, then one more
        expect_flag("full", full, 1'b1);
        send_random(1);
        expect_pulses();
        repeat (DEPTH) read_char();
        expect_flag("empty", empty, 1'b1);

        send_frame(8'h96, 1'b0, 1'b0, 5);  // start and 4 data bits, then stall
        step(`PS2_IDLE_TIMEOUT + 20);
        expect_flag("empty", empty, 1'b1);
        expect_pulses();
        send_random(1);
        read_char();

        read_char();  // empty buffer
        expect_flag("empty", empty, 1'b1);
        send_random(1);
        read_char();
        expect_flag("empty", empty, 1'b1);
        expect_pulses();

        $display("checks done, assertion errors %0d, sequence errors %0d",
                 check_errors, seq_errors);
        if (check_errors + seq_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
